/* verilog/ddr_wr_pkg.sv */
package ddr_wr_pkg;

    localparam int ADDR_W         = 28;  // word address, 32-bit units
    localparam int WORDS_PER_BEAT = 8;   // 256-bit DDR beat
    localparam int MAX_CHUNK      = 16;  // controller burst limit in beats

    // AXI write address channel payload
    typedef struct packed {
        logic [3:0]        id;
        logic [ADDR_W-1:0] addr;   // word units
        logic [7:0]        len;    // beats minus one
        logic [1:0]        burst;  // only INCR exists on DDR
    } axi_aw_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
        logic        last;
    } axi_w_t;

    typedef struct packed {
        logic [3:0] id;
        logic [1:0] resp;
    } axi_b_t;

    // one word on its way into the beat FIFO
    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
    } fifo_word_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [3:0]        len;   // beats minus one
        logic [3:0]        id;
    } ddr_wa_t;

    typedef struct packed {
        logic [32*WORDS_PER_BEAT-1:0] data;
        logic [4*WORDS_PER_BEAT-1:0]  strb;
    } ddr_wd_t;

    typedef enum logic [2:0] {
        IDLE,
        WAIT,
        TRANS_ADDR,
        TRANS_DATA,
        AFTER,
        RESP
    } write_st_e;

endpackage

/* verilog/rstn_sync.sv */
`timescale 1ns/1ps

module rstn_sync (
    input  logic clk,
    input  logic rstn,
    output logic ddr_rstn_sync
);

    logic rstn_meta;  // first stage, may go metastable

    // assert at once, release on the second edge
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rstn_meta     <= 1'b0;
            ddr_rstn_sync <= 1'b0;
        end else begin
            rstn_meta     <= 1'b1;
            ddr_rstn_sync <= rstn_meta;
        end
    end

endmodule

/* verilog/ddr_wr_fifo.sv */
`timescale 1ns/1ps

module ddr_wr_fifo #(
    parameter int FIFO_BEATS = 32
) (
    input  logic                                                  clk,
    input  logic                                                  ddr_rstn_sync,
    input  logic                                                  push,
    input  ddr_wr_pkg::fifo_word_t                                push_word,
    input  logic                                                  pop,
    output ddr_wr_pkg::ddr_wd_t                                   head,
    output logic [$clog2(FIFO_BEATS):0]                           beat_count,
    output logic [$clog2(FIFO_BEATS*ddr_wr_pkg::WORDS_PER_BEAT):0] free_words
);

    localparam int PTR_W  = $clog2(FIFO_BEATS);
    localparam int LANE_W = $clog2(ddr_wr_pkg::WORDS_PER_BEAT);
    localparam int FREE_W = $clog2(FIFO_BEATS * ddr_wr_pkg::WORDS_PER_BEAT) + 1;

    ddr_wr_pkg::ddr_wd_t mem [FIFO_BEATS];  // complete beats
    ddr_wr_pkg::ddr_wd_t stage;             // beat under assembly
    ddr_wr_pkg::ddr_wd_t stage_nxt;

    logic [LANE_W-1:0] wr_lane;  // next lane to fill
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic              beat_done;
    logic              pop_ok;

    // drop the incoming word into its lane
    always_comb begin
        stage_nxt = stage;
        stage_nxt.data[wr_lane*32 +: 32] = push_word.data;
        stage_nxt.strb[wr_lane*4 +: 4]   = push_word.strb;
    end

    assign beat_done = push && (wr_lane == LANE_W'(ddr_wr_pkg::WORDS_PER_BEAT - 1));
    assign pop_ok    = pop && (beat_count != '0);  // ignore pops on empty

    always_ff @(posedge clk) begin
        if (push) begin
            stage <= stage_nxt;
        end
        if (beat_done) begin
            mem[wr_ptr] <= stage_nxt;  // last lane goes straight in
        end
    end

    always_ff @(posedge clk or negedge ddr_rstn_sync) begin
        if (!ddr_rstn_sync) begin
            wr_lane <= '0;
        end else if (push) begin
            wr_lane <= wr_lane + 1'b1;  // wraps after the last lane
        end
    end

    always_ff @(posedge clk or negedge ddr_rstn_sync) begin
        if (!ddr_rstn_sync) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (beat_done) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge ddr_rstn_sync) begin
        if (!ddr_rstn_sync) begin
            beat_count <= '0;
        end else begin
            case ({beat_done, pop_ok})
                2'b10:   beat_count <= beat_count + 1'b1;
                2'b01:   beat_count <= beat_count - 1'b1;
                default: beat_count <= beat_count;  // both or neither
            endcase
        end
    end

    // show-ahead, oldest beat always visible
    assign head = mem[rd_ptr];

    // word slots left, staged lanes count as used
    assign free_words = FREE_W'(FIFO_BEATS * ddr_wr_pkg::WORDS_PER_BEAT)
                      - {beat_count, {LANE_W{1'b0}}}
                      - FREE_W'(wr_lane);

endmodule

/* verilog/ddr3_write.sv */
`timescale 1ns/1ps

module ddr3_write #(
    parameter int FIFO_BEATS = 32
) (
    input  logic                                                  clk,
    input  logic                                                  ddr_rstn_sync,

    input  ddr_wr_pkg::axi_aw_t                                   aw,
    input  logic                                                  aw_valid,
    output logic                                                  aw_ready,

    input  ddr_wr_pkg::axi_w_t                                    w,
    input  logic                                                  w_valid,
    output logic                                                  w_ready,

    output ddr_wr_pkg::axi_b_t                                    b,
    output logic                                                  b_valid,
    input  logic                                                  b_ready,

    output ddr_wr_pkg::ddr_wa_t                                   wa,
    output logic                                                  wa_valid,
    input  logic                                                  wa_ready,
    input  logic                                                  wd_ready,
    input  logic                                                  wd_last,

    output logic                                                  fifo_push,
    output ddr_wr_pkg::fifo_word_t                                fifo_word,
    input  logic [$clog2(FIFO_BEATS):0]                           beat_count,
    input  logic [$clog2(FIFO_BEATS*ddr_wr_pkg::WORDS_PER_BEAT):0] free_words
);

    localparam int AW = ddr_wr_pkg::ADDR_W;

    ddr_wr_pkg::write_st_e state;
    ddr_wr_pkg::write_st_e state_nxt;

    logic [3:0]    id_q;        // echoed on b
    logic [AW-1:0] chunk_addr;  // beat aligned
    logic [5:0]    beats_left;  // beats not yet sent to wa, at most 33
    logic [5:0]    chunk_beats;
    logic [2:0]    start_pad;
    logic [2:0]    end_pad;
    logic          last_seen;   // AXI last word taken

    logic [AW-1:0] end_addr;
    logic [AW-4:0] beat_span;
    logic          aw_fire;
    logic          w_fire;
    logic          wa_fire;
    logic          pad_start;
    logic          pad_end;
    logic          space;

    assign end_addr  = aw.addr + {{(AW-8){1'b0}}, aw.len};
    assign beat_span = end_addr[AW-1:3] - aw.addr[AW-1:3];

    assign aw_fire = aw_valid && aw_ready;
    assign w_fire  = w_valid && w_ready;
    assign wa_fire = wa_valid && wa_ready;
    assign space   = (free_words != '0);

    assign pad_start = (state == ddr_wr_pkg::WAIT) && (start_pad != 3'd0) && space;
    assign pad_end   = (state == ddr_wr_pkg::AFTER) && (end_pad != 3'd0) && space;

    // controller bursts are capped at MAX_CHUNK beats
    assign chunk_beats = (beats_left > 6'(ddr_wr_pkg::MAX_CHUNK)) ?
                         6'(ddr_wr_pkg::MAX_CHUNK) : beats_left;

    always_comb begin
        state_nxt = state;
        case (state)
            ddr_wr_pkg::IDLE: begin
                if (aw_fire) begin
                    state_nxt = ddr_wr_pkg::WAIT;
                end
            end
            ddr_wr_pkg::WAIT: begin
                if (start_pad == 3'd0 && beat_count >= chunk_beats) begin
                    state_nxt = ddr_wr_pkg::TRANS_ADDR;  // full chunk stored
                end else if (last_seen) begin
                    state_nxt = ddr_wr_pkg::AFTER;       // tail needs padding
                end
            end
            ddr_wr_pkg::AFTER: begin
                if (end_pad == 3'd0 && beat_count >= chunk_beats) begin
                    state_nxt = ddr_wr_pkg::TRANS_ADDR;
                end
            end
            ddr_wr_pkg::TRANS_ADDR: begin
                if (wa_fire) begin
                    state_nxt = ddr_wr_pkg::TRANS_DATA;
                end
            end
            ddr_wr_pkg::TRANS_DATA: begin
                if (wd_ready && wd_last) begin
                    // beats_left already dropped at the wa transfer
                    state_nxt = (beats_left == 6'd0) ? ddr_wr_pkg::RESP : ddr_wr_pkg::WAIT;
                end
            end
            ddr_wr_pkg::RESP: begin
                if (b_valid && b_ready) begin
                    state_nxt = ddr_wr_pkg::IDLE;
                end
            end
            default: state_nxt = ddr_wr_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge ddr_rstn_sync) begin
        if (!ddr_rstn_sync) begin
            state <= ddr_wr_pkg::IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk or negedge ddr_rstn_sync) begin
        if (!ddr_rstn_sync) begin
            beats_left <= '0;
            start_pad  <= '0;
            end_pad    <= '0;
            last_seen  <= 1'b0;
        end else if (aw_fire) begin
            beats_left <= beat_span[5:0] + 6'd1;
            start_pad  <= aw.addr[2:0];        // empty lanes before the data
            end_pad    <= 3'd7 - end_addr[2:0]; // empty lanes after it
            last_seen  <= 1'b0;
        end else begin
            if (wa_fire) begin
                beats_left <= beats_left - chunk_beats;
            end
            if (pad_start) begin
                start_pad <= start_pad - 3'd1;
            end
            if (pad_end) begin
                end_pad <= end_pad - 3'd1;
            end
            if (w_fire && w.last) begin
                last_seen <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire) begin
            id_q       <= aw.id;
            chunk_addr <= {aw.addr[AW-1:3], 3'b000};
        end else if (wa_fire) begin
            chunk_addr <= chunk_addr + {{(AW-9){1'b0}}, chunk_beats, 3'b000};
        end
    end

    // pad words win over AXI data, they never overlap in time
    assign fifo_push      = pad_start || pad_end || w_fire;
    assign fifo_word.data = (pad_start || pad_end) ? 32'd0 : w.data;
    assign fifo_word.strb = (pad_start || pad_end) ? 4'd0 : w.strb;

    assign aw_ready = (state == ddr_wr_pkg::IDLE);
    assign w_ready  = (state == ddr_wr_pkg::WAIT) && (start_pad == 3'd0) && !last_seen && space;

    assign wa.addr  = chunk_addr;
    assign wa.len   = 4'(chunk_beats - 6'd1);
    assign wa.id    = id_q;
    assign wa_valid = (state == ddr_wr_pkg::TRANS_ADDR);

    assign b.id    = id_q;  // one burst in flight, no reordering
    assign b.resp  = 2'b00;
    assign b_valid = (state == ddr_wr_pkg::RESP);

endmodule

/* verilog/ddr3_write_top.sv */
`timescale 1ns/1ps

module ddr3_write_top #(
    parameter int FIFO_BEATS = 32
) (
    input  logic                  clk,
    input  logic                  rstn,

    input  ddr_wr_pkg::axi_aw_t   aw,
    input  logic                  aw_valid,
    output logic                  aw_ready,
    input  ddr_wr_pkg::axi_w_t    w,
    input  logic                  w_valid,
    output logic                  w_ready,
    output ddr_wr_pkg::axi_b_t    b,
    output logic                  b_valid,
    input  logic                  b_ready,

    output ddr_wr_pkg::ddr_wa_t   wa,
    output logic                  wa_valid,
    input  logic                  wa_ready,
    output ddr_wr_pkg::ddr_wd_t   wd,
    input  logic                  wd_ready,
    input  logic                  wd_last
);

    localparam int CNT_W  = $clog2(FIFO_BEATS) + 1;
    localparam int FREE_W = $clog2(FIFO_BEATS * ddr_wr_pkg::WORDS_PER_BEAT) + 1;

    logic                   ddr_rstn_sync;
    logic                   fifo_push;
    ddr_wr_pkg::fifo_word_t fifo_word;
    logic [CNT_W-1:0]       beat_count;
    logic [FREE_W-1:0]      free_words;

    rstn_sync rstn_sync_i (
        .clk           (clk),
        .rstn          (rstn),
        .ddr_rstn_sync (ddr_rstn_sync)
    );

    ddr3_write #(
        .FIFO_BEATS (FIFO_BEATS)
    ) ddr3_write_i (
        .clk           (clk),
        .ddr_rstn_sync (ddr_rstn_sync),
        .aw            (aw),
        .aw_valid      (aw_valid),
        .aw_ready      (aw_ready),
        .w             (w),
        .w_valid       (w_valid),
        .w_ready       (w_ready),
        .b             (b),
        .b_valid       (b_valid),
        .b_ready       (b_ready),
        .wa            (wa),
        .wa_valid      (wa_valid),
        .wa_ready      (wa_ready),
        .wd_ready      (wd_ready),
        .wd_last       (wd_last),
        .fifo_push     (fifo_push),
        .fifo_word     (fifo_word),
        .beat_count    (beat_count),
        .free_words    (free_words)
    );

    ddr_wr_fifo #(
        .FIFO_BEATS (FIFO_BEATS)
    ) ddr_wr_fifo_i (
        .clk           (clk),
        .ddr_rstn_sync (ddr_rstn_sync),
        .push          (fifo_push),
        .push_word     (fifo_word),
        .pop           (wd_ready),  // controller takes a beat per ready
        .head          (wd),
        .beat_count    (beat_count),
        .free_words    (free_words)
    );

endmodule

/* test/ddr3_write_checker.sv */
`timescale 1ns/1ps

module ddr3_write_checker (
    input  logic                  clk,
    input  logic                  rstn,
    input  ddr_wr_pkg::axi_aw_t   aw,
    input  logic                  aw_valid,
    input  logic                  aw_ready,
    input  ddr_wr_pkg::axi_w_t    w,
    input  logic                  w_valid,
    input  logic                  w_ready,
    input  ddr_wr_pkg::axi_b_t    b,
    input  logic                  b_valid,
    input  logic                  b_ready,
    input  ddr_wr_pkg::ddr_wa_t   wa,
    input  logic                  wa_valid,
    input  logic                  wa_ready,
    input  ddr_wr_pkg::ddr_wd_t   wd,
    input  logic                  wd_ready,
    output int                    error_count,
    output int                    burst_count
);

    logic [35:0] exp_q [$];  // expected words in lane order, data and strobe
    logic        busy;
    logic [3:0]  exp_id;
    logic [27:0] exp_addr;
    logic [27:0] next_chunk;
    int          exp_len;
    int          total_beats;
    int          beats_left;    // not yet covered by a wa transfer
    int          beats_sent;    // sum of wa.len + 1
    int          beats_taken;
    int          burst_errs;
    int          rst_edges;

    task automatic mismatch(input string name, input logic [255:0] exp, input logic [255:0] got);
        $display("[ERROR] %0t %s expected %0h got %0h", $time, name, exp, got);
        error_count++;
        burst_errs++;
    endtask

    task automatic failure(input string what);
        $display("%0t %s", $time, what);
        error_count++;
        burst_errs++;
    endtask

    initial begin
        error_count = 0;
        burst_count = 0;
    end

    always @(posedge clk) begin
        logic [27:0]  end_addr;
        logic [35:0]  word;
        logic [255:0] exp_data;
        logic [31:0]  exp_strb;
        int           chunk;
        if (!rstn) begin
            exp_q.delete();
            busy      = 1'b0;
            rst_edges = 0;
        end else begin
            if (rst_edges < 4) rst_edges++;
            if (rst_edges == 3) begin  // synchronized reset has released
                if (aw_ready !== 1'b1) mismatch("aw_ready", 256'(1), 256'(aw_ready));
                if (w_ready !== 1'b0) mismatch("w_ready", 256'(0), 256'(w_ready));
                if (wa_valid !== 1'b0) mismatch("wa_valid", 256'(0), 256'(wa_valid));
                if (b_valid !== 1'b0) mismatch("b_valid", 256'(0), 256'(b_valid));
            end
            if (aw_valid && aw_ready) begin
                if (busy) failure("second address accepted before the response");
                busy        = 1'b1;
                burst_errs  = 0;
                exp_id      = aw.id;
                exp_addr    = aw.addr;
                exp_len     = int'(aw.len);
                end_addr    = aw.addr + 28'(aw.len);
                total_beats = int'(end_addr[27:3]) - int'(aw.addr[27:3]) + 1;
                beats_left  = total_beats;
                beats_sent  = 0;
                beats_taken = 0;
                next_chunk  = {aw.addr[27:3], 3'b000};
                for (int i = 0; i < int'(aw.addr[2:0]); i++) exp_q.push_back(36'd0);
            end
            if (w_valid && w_ready) begin
                exp_q.push_back({w.data, w.strb});
                if (w.last) begin
                    end_addr = exp_addr + 28'(exp_len);
                    for (int i = 0; i < 7 - int'(end_addr[2:0]); i++) exp_q.push_back(36'd0);
                end
            end
            if (wa_valid && wa_ready) begin
                if (beats_left <= 0) begin
                    failure("controller address with no beats left in the burst");
                end else begin
                    chunk = (beats_left > 16) ? 16 : beats_left;
                    if (wa.addr !== next_chunk) mismatch("wa.addr", 256'(next_chunk), 256'(wa.addr));
                    if (wa.len !== 4'(chunk - 1)) mismatch("wa.len", 256'(chunk - 1), 256'(wa.len));
                    if (wa.id !== exp_id) mismatch("wa.id", 256'(exp_id), 256'(wa.id));
                    next_chunk = next_chunk + 28'(chunk * 8);
                    beats_left = beats_left - chunk;
                    beats_sent = beats_sent + int'(wa.len) + 1;
                end
            end
            if (wd_ready) begin
                if (exp_q.size() < 8) begin
                    failure("controller took a beat before eight words were written");
                end else begin
                    for (int k = 0; k < 8; k++) begin
                        word = exp_q.pop_front();
                        exp_data[k*32 +: 32] = word[35:4];
                        exp_strb[k*4 +: 4]   = word[3:0];
                    end
                    if (wd.data !== exp_data) mismatch("wd.data", exp_data, wd.data);
                    if (wd.strb !== exp_strb) mismatch("wd.strb", 256'(exp_strb), 256'(wd.strb));
                end
                beats_taken++;
            end
            if (b_valid && b_ready) begin
                if (!busy) begin
                    failure("write response without an open burst");
                end else begin
                    if (b.id !== exp_id) mismatch("b.id", 256'(exp_id), 256'(b.id));
                    if (b.resp !== 2'b00) mismatch("b.resp", 256'(0), 256'(b.resp));
                    if (beats_sent != total_beats) begin
                        mismatch("chunk beat sum", 256'(total_beats), 256'(beats_sent));
                    end
                    if (beats_taken != total_beats) begin
                        mismatch("beats taken", 256'(total_beats), 256'(beats_taken));
                    end
                    if (exp_q.size() != 0) failure("response while expected words remain unwritten");
                    $display("burst %0d id %0h addr %0h len %0d beats %0d: %s", burst_count, exp_id,
                             exp_addr, exp_len, total_beats, (burst_errs == 0) ? "ok" : "mismatch");
                    burst_count++;
                end
                busy = 1'b0;
            end
        end
    end

endmodule

/* test/tb_ddr3_write.sv */
`timescale 1ns/1ps

module tb_ddr3_write;

    localparam int N_BURSTS = 40;
    localparam int TIMEOUT  = 4000;  // cycles per wait

    logic                clk;
    logic                rstn;
    ddr_wr_pkg::axi_aw_t aw;
    logic                aw_valid;
    logic                aw_ready;
    ddr_wr_pkg::axi_w_t  w;
    logic                w_valid;
    logic                w_ready;
    ddr_wr_pkg::axi_b_t  b;
    logic                b_valid;
    logic                b_ready = 1'b0;
    ddr_wr_pkg::ddr_wa_t wa;
    logic                wa_valid;
    logic                wa_ready = 1'b0;
    ddr_wr_pkg::ddr_wd_t wd;
    logic                wd_ready = 1'b0;
    logic                wd_last = 1'b0;

    logic [31:0] seed_axi;
    logic [31:0] seed_ddr = 32'h22489775 ^ 32'h5a5a5a5a;  // controller side stream
    int          pending;    // beats left in the accepted chunk
    logic        timed_out;
    int          errors;
    int          checked;

    ddr3_write_top #(.FIFO_BEATS(32)) ddr3_write_top_i (
        .clk(clk), .rstn(rstn),
        .aw(aw), .aw_valid(aw_valid), .aw_ready(aw_ready),
        .w(w), .w_valid(w_valid), .w_ready(w_ready),
        .b(b), .b_valid(b_valid), .b_ready(b_ready),
        .wa(wa), .wa_valid(wa_valid), .wa_ready(wa_ready),
        .wd(wd), .wd_ready(wd_ready), .wd_last(wd_last)
    );

    ddr3_write_checker ddr3_write_checker_i (
        .clk(clk), .rstn(rstn),
        .aw(aw), .aw_valid(aw_valid), .aw_ready(aw_ready),
        .w(w), .w_valid(w_valid), .w_ready(w_ready),
        .b(b), .b_valid(b_valid), .b_ready(b_ready),
        .wa(wa), .wa_valid(wa_valid), .wa_ready(wa_ready),
        .wd(wd), .wd_ready(wd_ready),
        .error_count(errors), .burst_count(checked)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic handshake_seen(input int chan);
        case (chan)
            0:       return aw_ready;
            1:       return w_ready;
            default: return b_valid && b_ready;
        endcase
    endfunction

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // controller model, chunk bookkeeping on the rising edge
    always @(posedge clk) begin
        if (!rstn) pending <= 0;
        else if (wa_valid && wa_ready) pending <= int'(wa.len) + 1;
        else if (wd_ready) pending <= pending - 1;
    end

    always @(negedge clk) begin
        seed_ddr = xorshift(seed_ddr);
        wa_ready = rstn && wa_valid && (pending == 0) && seed_ddr[0];
        wd_ready = rstn && (pending > 0) && (seed_ddr[1] || seed_ddr[2]);  // about 3 in 4
        wd_last  = wd_ready && (pending == 1);
        b_ready  = rstn && seed_ddr[3];
    end

    task automatic wait_handshake(input int chan, input string what);
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (!handshake_seen(chan) && !timed_out) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("%0t timeout while waiting for %s", $time, what);
                timed_out = 1'b1;
            end else begin
                @(posedge clk);
            end
        end
    endtask

    task automatic offer_address(input int idx);
        int len;
        seed_axi = xorshift(seed_axi);
        len      = (idx % 4 == 3) ? 255 : int'(seed_axi[7:0]);  // every fourth one is long
        aw.id    = seed_axi[11:8];
        aw.len   = 8'(len);
        aw.burst = 2'b01;
        seed_axi = xorshift(seed_axi);
        aw.addr  = {1'b0, seed_axi[26:0]};
        aw_valid = 1'b1;
    endtask

    task automatic send_burst(input int idx);
        int len;
        int gap;
        len = int'(aw.len);
        wait_handshake(0, "AXI address ready");
        @(negedge clk);
        aw_valid = 1'b0;
        for (int i = 0; i <= len && !timed_out; i++) begin
            seed_axi = xorshift(seed_axi);
            gap      = (seed_axi[1:0] == 2'b00) ? int'(seed_axi[3:2]) : 0;
            w_valid  = 1'b0;
            repeat (gap) @(negedge clk);
            seed_axi = xorshift(seed_axi);
            w.data   = seed_axi;
            w.strb   = seed_axi[7:4] ^ seed_axi[31:28];
            w.last   = (i == len);
            w_valid  = 1'b1;
            wait_handshake(1, "AXI data ready");
            @(negedge clk);
        end
        w_valid = 1'b0;
        if (!timed_out) begin
            if (idx + 1 < N_BURSTS) begin
                offer_address(idx + 1);  // next address waits behind the response
            end
            wait_handshake(2, "write response");
            @(negedge clk);
        end
    endtask

    initial begin
        rstn      = 1'b0;
        aw        = '0;
        aw_valid  = 1'b0;
        w         = '0;
        w_valid   = 1'b0;
        timed_out = 1'b0;
        seed_axi  = 32'h22489775;
        repeat (2) @(negedge clk);
        rstn = 1'b1;
        repeat (4) @(negedge clk);
        offer_address(0);
        for (int n = 0; n < N_BURSTS && !timed_out; n++) begin
            send_burst(n);
        end
        repeat (10) @(negedge clk);
        $display("bursts issued %0d, checked %0d, errors %0d", N_BURSTS, checked, errors);
        if (!timed_out && errors == 0 && checked == N_BURSTS) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* flist.f */
verilog/ddr_wr_pkg.sv
verilog/rstn_sync.sv
verilog/ddr_wr_fifo.sv
verilog/ddr3_write.sv
verilog/ddr3_write_top.sv
test/ddr3_write_checker.sv
test/tb_ddr3_write.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the DDR3 write path testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module tb_ddr3_write \
    -f flist.f \
    -o sim_tb

output="$(./obj_dir/sim_tb)"
echo "$output"

if echo "$output" | grep -qx "Test passed"; then
    exit 0
fi
exit 1
